/* Makefile */
# Verilator build and run of the VGA controller testbench
TOP := tb_vga_subsys

simulate:
	verilator --binary --assert -j 0 --top-module $(TOP) -f vga_subsys.f
	./obj_dir/V$(TOP) 2>&1 | tee sim.log
	grep -qx "Regression passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: simulate clean

/* src/apb_vga_regs.sv */
/*
 * APB control registers of the video controller
 * holds enable, pattern mode, solid colour and bar shift, and counts
 * frames while enabled. zero wait states, unknown offsets flag pslverr
 */
module apb_vga_regs (
   input  logic                                 clk_85MHz,
   input  logic                                 rst_n,
   input  logic                                 psel,
   input  logic                                 penable,
   input  logic                                 pwrite,
   input  logic [vga_regmap_pkg::ADDR_W-1:0]    paddr,
   input  logic [vga_regmap_pkg::DATA_W-1:0]    pwdata,
   output logic [vga_regmap_pkg::DATA_W-1:0]    prdata,
   output logic                                 pready,
   output logic                                 pslverr,
   input  logic                                 frame_start,
   output logic                                 enable,
   output vga_video_pkg::pattern_mode_e         mode,
   output vga_video_pkg::rgb_t                  solid_color,
   output logic [vga_regmap_pkg::BARW_W-1:0]    bar_shift
);

   logic [vga_regmap_pkg::FRAMES_W-1:0] frame_cnt;
   logic                                addr_ok;
   logic                                wr_en;
   logic [vga_regmap_pkg::DATA_W-1:0]   rd_mux;

   // ------------------------------------------------------------------------
   // address decode
   // ------------------------------------------------------------------------
   assign addr_ok = (paddr == vga_regmap_pkg::REG_CTRL)  ||
                    (paddr == vga_regmap_pkg::REG_COLOR) ||
                    (paddr == vga_regmap_pkg::REG_BARW)  ||
                    (paddr == vga_regmap_pkg::REG_FRAMES);

   // write lands in the access cycle, bad offsets are ignored
   assign wr_en   = psel && penable && pwrite && addr_ok;

   // no wait states
   assign pready  = 1'b1;
   assign pslverr = psel && penable && !addr_ok;

   // ------------------------------------------------------------------------
   // control registers
   // ------------------------------------------------------------------------
   always_ff @(posedge clk_85MHz or negedge rst_n)
   begin
      if (!rst_n)
      begin
         enable      <= 1'b0;
         mode        <= vga_video_pkg::PAT_SOLID;
         solid_color <= '0;
         bar_shift   <= '0;
      end
      else if (wr_en)
      begin
         case (paddr)
            vga_regmap_pkg::REG_CTRL:
            begin
               enable <= pwdata[vga_regmap_pkg::CTRL_EN_BIT];
               // raw cast, reserved code 3 is kept and shows black
               mode   <= vga_video_pkg::pattern_mode_e'(
                         pwdata[vga_regmap_pkg::CTRL_MODE_MSB:vga_regmap_pkg::CTRL_MODE_LSB]);
            end
            vga_regmap_pkg::REG_COLOR:
               solid_color <= pwdata[vga_regmap_pkg::COLOR_W-1:0];
            vga_regmap_pkg::REG_BARW:
               bar_shift <= pwdata[vga_regmap_pkg::BARW_W-1:0];
            default:
            begin
               // frames handled below
            end
         endcase
      end
   end

   // frame counter, a write clears it and wins over a count
   always_ff @(posedge clk_85MHz or negedge rst_n)
   begin
      if (!rst_n)
         frame_cnt <= '0;
      else if (wr_en && paddr == vga_regmap_pkg::REG_FRAMES)
         frame_cnt <= '0;
      else if (frame_start && enable)
         frame_cnt <= frame_cnt + 1'b1;
   end

   // ------------------------------------------------------------------------
   // read path, zero unless a read is selected
   // ------------------------------------------------------------------------
   always_comb
   begin
      rd_mux = '0;
      case (paddr)
         vga_regmap_pkg::REG_CTRL:
         begin
            rd_mux[vga_regmap_pkg::CTRL_EN_BIT] = enable;
            rd_mux[vga_regmap_pkg::CTRL_MODE_MSB:vga_regmap_pkg::CTRL_MODE_LSB] = mode;
         end
         vga_regmap_pkg::REG_COLOR:  rd_mux[vga_regmap_pkg::COLOR_W-1:0]  = solid_color;
         vga_regmap_pkg::REG_BARW:   rd_mux[vga_regmap_pkg::BARW_W-1:0]   = bar_shift;
         vga_regmap_pkg::REG_FRAMES: rd_mux[vga_regmap_pkg::FRAMES_W-1:0] = frame_cnt;
         default:                    rd_mux = '0;
      endcase
   end

   assign prdata = (psel && !pwrite) ? rd_mux : '0;

   // access phase must follow a setup phase with psel held
   a_penable_needs_psel: assert property (
      @(posedge clk_85MHz) disable iff (!rst_n) penable |-> psel);

endmodule

/* src/pattern_gen.sv */
/*
 * test pattern generator
 * registers one colour per pixel from the coordinates: solid colour,
 * colour bars or a checkerboard of 4x4 squares
 */
module pattern_gen (
   input  logic                          clk_85MHz,
   input  logic                          rst_n,
   input  vga_video_pkg::pattern_mode_e  mode,
   input  vga_video_pkg::rgb_t           solid_color,
   input  logic [3:0]                    bar_shift,
   input  vga_video_pkg::coord_t         x,
   input  vga_video_pkg::coord_t         y,
   output vga_video_pkg::rgb_t           color
);

   vga_video_pkg::rgb_t color_next;
   vga_video_pkg::rgb_t bar_color;
   logic                checker_on;

   // bar index is x over the bar width, low 3 bits pick the colour
   assign bar_color  = vga_video_pkg::rgb_t'(x >> bar_shift);

   // squares of 4 pixels
   assign checker_on = x[2] ^ y[2];

   always_comb
   begin
      case (mode)
         vga_video_pkg::PAT_SOLID:   color_next = solid_color;
         vga_video_pkg::PAT_BARS:    color_next = bar_color;
         vga_video_pkg::PAT_CHECKER: color_next = checker_on ? 3'b111 : 3'b000;
         // reserved mode shows black
         default:                    color_next = 3'b000;
      endcase
   end

   // ------------------------------------------------------------------------
   // one cycle behind the timing signals
   // ------------------------------------------------------------------------
   always_ff @(posedge clk_85MHz or negedge rst_n)
   begin
      if (!rst_n)
         color <= '0;
      else
         color <= color_next;
   end

endmodule

/* src/raster_timing_gen.sv */
/*
 * raster timing generator
 * horizontal and vertical counters with blanking first, then active
 * video. sync, active, coordinates and frame start are decoded from the
 * counters and registered
 */
module raster_timing_gen #(
   parameter int H_ACTIVE = 640,
   parameter int V_ACTIVE = 480,
   parameter int HFP      = 32,
   parameter int H_PULSE  = 48,
   parameter int HBP      = 112,
   parameter int VFP      = 1,
   parameter int V_PULSE  = 3,
   parameter int VBP      = 25
) (
   input  logic                  clk_85MHz,
   input  logic                  rst_n,
   input  logic                  enable,
   output logic                  hsync_raw,
   output logic                  vsync_raw,
   output logic                  active,
   output vga_video_pkg::coord_t x,
   output vga_video_pkg::coord_t y,
   output logic                  frame_start
);

   // blanking lengths and totals
   localparam int BLACK_H = HFP + H_PULSE + HBP;
   localparam int BLACK_V = VFP + V_PULSE + VBP;
   localparam int H_TOTAL = BLACK_H + H_ACTIVE;
   localparam int V_TOTAL = BLACK_V + V_ACTIVE;
   localparam int H_CW    = $clog2(H_TOTAL);
   localparam int V_CW    = $clog2(V_TOTAL);

   // decode points at counter width
   localparam logic [H_CW-1:0] H_SYNC_ON  = H_CW'(HFP);
   localparam logic [H_CW-1:0] H_SYNC_OFF = H_CW'(HFP + H_PULSE);
   localparam logic [H_CW-1:0] H_ACT_ON   = H_CW'(BLACK_H);
   localparam logic [H_CW-1:0] H_LAST     = H_CW'(H_TOTAL - 1);
   localparam logic [V_CW-1:0] V_SYNC_ON  = V_CW'(VFP);
   localparam logic [V_CW-1:0] V_SYNC_OFF = V_CW'(VFP + V_PULSE);
   localparam logic [V_CW-1:0] V_ACT_ON   = V_CW'(BLACK_V);
   localparam logic [V_CW-1:0] V_LAST     = V_CW'(V_TOTAL - 1);

   logic [H_CW-1:0] h_cnt;
   logic [V_CW-1:0] v_cnt;
   logic            act_now;

   // ------------------------------------------------------------------------
   // counters, held at zero while disabled
   // ------------------------------------------------------------------------
   always_ff @(posedge clk_85MHz or negedge rst_n)
   begin
      if (!rst_n)
      begin
         h_cnt <= '0;
         v_cnt <= '0;
      end
      else if (!enable)
      begin
         h_cnt <= '0;
         v_cnt <= '0;
      end
      else if (h_cnt == H_LAST)
      begin
         // end of line steps the line counter
         h_cnt <= '0;
         v_cnt <= (v_cnt == V_LAST) ? '0 : v_cnt + 1'b1;
      end
      else
         h_cnt <= h_cnt + 1'b1;
   end

   assign act_now = (h_cnt >= H_ACT_ON) && (v_cnt >= V_ACT_ON);

   // ------------------------------------------------------------------------
   // registered decode, syncs active low
   // ------------------------------------------------------------------------
   always_ff @(posedge clk_85MHz or negedge rst_n)
   begin
      if (!rst_n)
      begin
         hsync_raw   <= 1'b1;
         vsync_raw   <= 1'b1;
         active      <= 1'b0;
         x           <= '0;
         y           <= '0;
         frame_start <= 1'b0;
      end
      else
      begin
         hsync_raw   <= !(enable && h_cnt >= H_SYNC_ON && h_cnt < H_SYNC_OFF);
         vsync_raw   <= !(enable && v_cnt >= V_SYNC_ON && v_cnt < V_SYNC_OFF);
         active      <= enable && act_now;
         // coordinates only inside active video
         x           <= (enable && act_now) ? vga_video_pkg::coord_t'(h_cnt - H_ACT_ON) : '0;
         y           <= (enable && act_now) ? vga_video_pkg::coord_t'(v_cnt - V_ACT_ON) : '0;
         // first active pixel of the frame
         frame_start <= enable && (h_cnt == H_ACT_ON) && (v_cnt == V_ACT_ON);
      end
   end

   a_h_cnt_in_line: assert property (
      @(posedge clk_85MHz) disable iff (!rst_n) h_cnt <= H_LAST);

endmodule

/* src/vga_output_stage.sv */
/*
 * video output stage
 * delays sync, active and coordinates one cycle to meet the pattern
 * colour, and blanks the colour outside active video
 */
module vga_output_stage (
   input  logic                  clk_85MHz,
   input  logic                  rst_n,
   input  logic                  hsync_raw,
   input  logic                  vsync_raw,
   input  logic                  active,
   input  vga_video_pkg::coord_t x_in,
   input  vga_video_pkg::coord_t y_in,
   input  vga_video_pkg::rgb_t   color,
   output logic                  hsync,
   output logic                  vsync,
   output vga_video_pkg::rgb_t   rgb,
   output vga_video_pkg::coord_t x,
   output vga_video_pkg::coord_t y
);

   logic active_d;

   // syncs idle high out of reset
   always_ff @(posedge clk_85MHz or negedge rst_n)
   begin
      if (!rst_n)
      begin
         hsync    <= 1'b1;
         vsync    <= 1'b1;
         active_d <= 1'b0;
         x        <= '0;
         y        <= '0;
      end
      else
      begin
         hsync    <= hsync_raw;
         vsync    <= vsync_raw;
         active_d <= active;
         x        <= x_in;
         y        <= y_in;
      end
   end

   // colour is already registered, blank with the aligned flag
   assign rgb = active_d ? color : '0;

   // hsync pulse sits in horizontal blanking
   a_dark_in_hsync: assert property (
      @(posedge clk_85MHz) disable iff (!rst_n) !hsync |-> (rgb == '0));

endmodule

/* src/vga_regmap_pkg.sv */
/*
 * register map of the video controller
 * APB widths, register offsets and control field positions
 */
package vga_regmap_pkg;

   localparam int ADDR_W = 8;
   localparam int DATA_W = 32;

   // register offsets
   localparam logic [ADDR_W-1:0] REG_CTRL   = 8'h00;
   localparam logic [ADDR_W-1:0] REG_COLOR  = 8'h04;
   localparam logic [ADDR_W-1:0] REG_BARW   = 8'h08;
   localparam logic [ADDR_W-1:0] REG_FRAMES = 8'h0C;

   // ctrl fields: enable in bit 0, mode in bits 2:1
   localparam int CTRL_EN_BIT   = 0;
   localparam int CTRL_MODE_LSB = 1;
   localparam int CTRL_MODE_MSB = 2;

   // colour, bar shift and frame count field widths
   localparam int COLOR_W  = 3;
   localparam int BARW_W   = 4;
   localparam int FRAMES_W = 16;

endpackage

/* src/vga_subsys_top.sv */
/*
 * VGA video controller top level
 * APB register block, raster timing, pattern generator and output stage
 * on one clock, timing set by the parameters below
 */
module vga_subsys_top #(
   parameter int H_ACTIVE = 640,
   parameter int V_ACTIVE = 480,
   parameter int HFP      = 32,
   parameter int H_PULSE  = 48,
   parameter int HBP      = 112,
   parameter int VFP      = 1,
   parameter int V_PULSE  = 3,
   parameter int VBP      = 25
) (
   input  logic                              clk_85MHz,
   input  logic                              rst_n,
   input  logic                              psel,
   input  logic                              penable,
   input  logic                              pwrite,
   input  logic [vga_regmap_pkg::ADDR_W-1:0] paddr,
   input  logic [vga_regmap_pkg::DATA_W-1:0] pwdata,
   output logic [vga_regmap_pkg::DATA_W-1:0] prdata,
   output logic                              pready,
   output logic                              pslverr,
   output logic                              hsync,
   output logic                              vsync,
   output vga_video_pkg::rgb_t               rgb,
   output vga_video_pkg::coord_t             x,
   output vga_video_pkg::coord_t             y
);

   // control from the register block
   logic                                     enable;
   vga_video_pkg::pattern_mode_e             mode;
   vga_video_pkg::rgb_t                      solid_color;
   logic [vga_regmap_pkg::BARW_W-1:0]        bar_shift;

   // timing stage outputs
   logic                                     hsync_raw;
   logic                                     vsync_raw;
   logic                                     active;
   vga_video_pkg::coord_t                    x_raw;
   vga_video_pkg::coord_t                    y_raw;
   logic                                     frame_start;
   vga_video_pkg::rgb_t                      color;

   apb_vga_regs u_regs (
      .clk_85MHz   (clk_85MHz),
      .rst_n       (rst_n),
      .psel        (psel),
      .penable     (penable),
      .pwrite      (pwrite),
      .paddr       (paddr),
      .pwdata      (pwdata),
      .prdata      (prdata),
      .pready      (pready),
      .pslverr     (pslverr),
      .frame_start (frame_start),
      .enable      (enable),
      .mode        (mode),
      .solid_color (solid_color),
      .bar_shift   (bar_shift)
   );

   raster_timing_gen #(
      .H_ACTIVE (H_ACTIVE),
      .V_ACTIVE (V_ACTIVE),
      .HFP      (HFP),
      .H_PULSE  (H_PULSE),
      .HBP      (HBP),
      .VFP      (VFP),
      .V_PULSE  (V_PULSE),
      .VBP      (VBP)
   ) u_timing (
      .clk_85MHz   (clk_85MHz),
      .rst_n       (rst_n),
      .enable      (enable),
      .hsync_raw   (hsync_raw),
      .vsync_raw   (vsync_raw),
      .active      (active),
      .x           (x_raw),
      .y           (y_raw),
      .frame_start (frame_start)
   );

   // pattern register runs beside the output stage
   pattern_gen u_pattern (
      .clk_85MHz   (clk_85MHz),
      .rst_n       (rst_n),
      .mode        (mode),
      .solid_color (solid_color),
      .bar_shift   (bar_shift),
      .x           (x_raw),
      .y           (y_raw),
      .color       (color)
   );

   vga_output_stage u_out (
      .clk_85MHz (clk_85MHz),
      .rst_n     (rst_n),
      .hsync_raw (hsync_raw),
      .vsync_raw (vsync_raw),
      .active    (active),
      .x_in      (x_raw),
      .y_in      (y_raw),
      .color     (color),
      .hsync     (hsync),
      .vsync     (vsync),
      .rgb       (rgb),
      .x         (x),
      .y         (y)
   );

endmodule

/* src/vga_video_pkg.sv */
/*
 * video format definitions
 * colour and coordinate types shared by the raster, pattern and output
 * blocks, plus the pattern mode encoding
 */
package vga_video_pkg;

   // pixel coordinate width, covers 640x480 and below
   localparam int COORD_W = 10;

   // one bit per channel: red msb, then green, then blue
   typedef logic [2:0] rgb_t;

   typedef logic [COORD_W-1:0] coord_t;

   // value 3 is reserved and shows black
   typedef enum logic [1:0] {
      PAT_SOLID   = 2'd0,
      PAT_BARS    = 2'd1,
      PAT_CHECKER = 2'd2
   } pattern_mode_e;

endpackage

/* tests/tb_vga_checks.svh */
/*
 * testbench compare tasks
 * typed checks for register data, colour and coordinates, plus the
 * error counters and the closing count line
 */
`ifndef TB_VGA_CHECKS_SVH
`define TB_VGA_CHECKS_SVH

   typedef logic [vga_regmap_pkg::DATA_W-1:0] data_t;

   int check_count  = 0;
   int value_errors = 0;
   int other_errors = 0;

   task automatic check_data(input string name, input data_t got, input data_t exp);
      check_count++;
      if (got !== exp)
      begin
         value_errors++;
         $display("CHECK FAILED at %0t: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
      end
   endtask

   task automatic check_rgb(input string name, input vga_video_pkg::rgb_t got,
                            input vga_video_pkg::rgb_t exp);
      check_count++;
      if (got !== exp)
      begin
         value_errors++;
         $display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
      end
   endtask

   task automatic check_coord(input string name, input vga_video_pkg::coord_t got,
                              input vga_video_pkg::coord_t exp);
      check_count++;
      if (got !== exp)
      begin
         value_errors++;
         $display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, name, got, exp);
      end
   endtask

   // timeouts and other non-value failures
   task automatic note_failure(input string what);
      other_errors++;
      $display("ERROR at %0t: %s", $time, what);
   endtask

   task automatic print_counts();
      $display("checks %0d, value errors %0d, other errors %0d",
               check_count, value_errors, other_errors);
   endtask

`endif

/* tests/tb_vga_subsys.sv */
/*
 * testbench of the VGA video controller
 * APB register access, sync timing, solid, bar and checker patterns,
 * frame counter and disable, on a small 16x8 raster
 */
module tb_vga_subsys;

   // small raster, 25 cycles per line and 13 lines per frame
   localparam int H_ACTIVE   = 16;
   localparam int V_ACTIVE   = 8;
   localparam int HFP        = 2;
   localparam int H_PULSE    = 3;
   localparam int HBP        = 4;
   localparam int VFP        = 1;
   localparam int V_PULSE    = 2;
   localparam int VBP        = 2;
   localparam int H_BLANK    = HFP + H_PULSE + HBP;
   localparam int V_BLANK    = VFP + V_PULSE + VBP;
   localparam int H_TOTAL    = H_BLANK + H_ACTIVE;
   localparam int V_TOTAL    = V_BLANK + V_ACTIVE;
   localparam int WAIT_LIMIT = 4 * H_TOTAL * V_TOTAL;
   localparam int N_FRAMES   = 3;

   typedef logic [vga_regmap_pkg::ADDR_W-1:0] addr_t;

   logic                  clk_85MHz;
   logic                  rst_n;
   logic                  psel;
   logic                  penable;
   logic                  pwrite;
   addr_t                 paddr;
   logic [31:0]           pwdata;
   logic [31:0]           prdata;
   logic                  pready;
   logic                  pslverr;
   logic                  hsync;
   logic                  vsync;
   vga_video_pkg::rgb_t   rgb;
   vga_video_pkg::coord_t x;
   vga_video_pkg::coord_t y;

   int seed = 51;

   // what software has programmed, for the expected colour
   vga_video_pkg::pattern_mode_e cur_mode;
   vga_video_pkg::rgb_t          cur_color;
   logic [3:0]                   cur_shift;

   `include "tb_vga_checks.svh"

   vga_subsys_top #(
      .H_ACTIVE (H_ACTIVE),
      .V_ACTIVE (V_ACTIVE),
      .HFP      (HFP),
      .H_PULSE  (H_PULSE),
      .HBP      (HBP),
      .VFP      (VFP),
      .V_PULSE  (V_PULSE),
      .VBP      (VBP)
   ) uut (
      .clk_85MHz (clk_85MHz),
      .rst_n     (rst_n),
      .psel      (psel),
      .penable   (penable),
      .pwrite    (pwrite),
      .paddr     (paddr),
      .pwdata    (pwdata),
      .prdata    (prdata),
      .pready    (pready),
      .pslverr   (pslverr),
      .hsync     (hsync),
      .vsync     (vsync),
      .rgb       (rgb),
      .x         (x),
      .y         (y)
   );

   initial
   begin
      clk_85MHz = 1'b0;
      forever #4 clk_85MHz = ~clk_85MHz;
   end

   // ------------------------------------------------------------------------
   // APB driver, setup then access, response taken mid access cycle
   // ------------------------------------------------------------------------
   task automatic apb_xfer(input logic wr, input addr_t addr, input data_t wdata,
                           output data_t rdata, output logic err);
      int waited;
      @(posedge clk_85MHz);
      #1;
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = wr;
      paddr   = addr;
      pwdata  = wdata;
      @(posedge clk_85MHz);
      #1;
      penable = 1'b1;
      @(negedge clk_85MHz);
      waited = 0;
      while (pready !== 1'b1 && waited <= WAIT_LIMIT)
      begin
         @(negedge clk_85MHz);
         waited++;
      end
      if (waited > WAIT_LIMIT)
         note_failure("APB transfer timed out waiting for pready");
      rdata = prdata;
      err   = pslverr;
      @(posedge clk_85MHz);
      #1;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   task automatic apb_write(input addr_t addr, input data_t wdata, output logic err);
      data_t rd_ignored;
      apb_xfer(1'b1, addr, wdata, rd_ignored, err);
   endtask

   task automatic apb_read(input addr_t addr, output data_t rdata, output logic err);
      apb_xfer(1'b0, addr, '0, rdata, err);
   endtask

   task automatic set_ctrl(input logic en, input vga_video_pkg::pattern_mode_e m);
      data_t wdata;
      logic  err;
      wdata      = '0;
      wdata[0]   = en;
      wdata[2:1] = m;
      cur_mode   = m;
      apb_write(vga_regmap_pkg::REG_CTRL, wdata, err);
   endtask

   // sample at falling edges until a sync reaches the level
   task automatic wait_sync(input logic use_v, input logic level, output int cycles);
      cycles = 0;
      while (((use_v ? vsync : hsync) !== level) && cycles <= WAIT_LIMIT)
      begin
         @(negedge clk_85MHz);
         cycles++;
      end
      if (cycles > WAIT_LIMIT)
         note_failure(use_v ? "timed out waiting for vsync" : "timed out waiting for hsync");
   endtask

   // colour rules: solid, bars 2^shift pixels wide cycling through 8 colours,
   // 4 pixel checker squares
   function automatic vga_video_pkg::rgb_t expected_color(input vga_video_pkg::coord_t cx,
                                                          input vga_video_pkg::coord_t cy);
      int bar_w;
      int bar_idx;
      bar_w   = 1 << cur_shift;
      bar_idx = int'(cx) / bar_w;
      case (cur_mode)
         vga_video_pkg::PAT_SOLID:   return cur_color;
         vga_video_pkg::PAT_BARS:    return vga_video_pkg::rgb_t'(bar_idx % 8);
         vga_video_pkg::PAT_CHECKER: return (cx[2] != cy[2]) ? 3'b111 : 3'b000;
         default:                    return 3'b000;
      endcase
   endfunction

   // ------------------------------------------------------------------------
   // one full frame against a raster model started at vsync rise
   // ------------------------------------------------------------------------
   task automatic scan_frame();
      int                    n;
      int                    hpos;
      int                    vline;
      int                    waited;
      logic                  in_act;
      vga_video_pkg::coord_t ex;
      vga_video_pkg::coord_t ey;
      wait_sync(1'b1, 1'b0, waited);
      wait_sync(1'b1, 1'b1, waited);
      // vsync rises at the start of the first back porch line
      hpos  = 0;
      vline = VFP + V_PULSE;
      for (n = 0; n < H_TOTAL * V_TOTAL; n++)
      begin
         in_act = (hpos >= H_BLANK) && (vline >= V_BLANK);
         ex     = in_act ? vga_video_pkg::coord_t'(hpos - H_BLANK) : '0;
         ey     = in_act ? vga_video_pkg::coord_t'(vline - V_BLANK) : '0;
         check_data("hsync", data_t'(hsync),
                    data_t'(!(hpos >= HFP && hpos < HFP + H_PULSE)));
         check_data("vsync", data_t'(vsync),
                    data_t'(!(vline >= VFP && vline < VFP + V_PULSE)));
         check_coord("x", x, ex);
         check_coord("y", y, ey);
         check_rgb("rgb", rgb, in_act ? expected_color(ex, ey) : 3'b000);
         @(negedge clk_85MHz);
         hpos++;
         if (hpos == H_TOTAL)
         begin
            hpos  = 0;
            vline = (vline + 1) % V_TOTAL;
         end
      end
   endtask

   // ------------------------------------------------------------------------
   // directed tests
   // ------------------------------------------------------------------------
   task automatic reset_state();
      @(negedge clk_85MHz);
      check_data("hsync", data_t'(hsync), 32'd1);
      check_data("vsync", data_t'(vsync), 32'd1);
      check_rgb("rgb", rgb, 3'b000);
      check_data("prdata", prdata, '0);
   endtask

   task automatic register_access();
      int    i;
      data_t val;
      data_t rd;
      logic  err;
      for (i = 0; i < 4; i++)
      begin
         val = $random(seed);
         apb_write(vga_regmap_pkg::REG_COLOR, val, err);
         apb_read(vga_regmap_pkg::REG_COLOR, rd, err);
         check_data("color reg", rd, val & 32'h7);
         check_data("pslverr", data_t'(err), '0);
         val = $random(seed);
         apb_write(vga_regmap_pkg::REG_BARW, val, err);
         apb_read(vga_regmap_pkg::REG_BARW, rd, err);
         check_data("barw reg", rd, val & 32'hF);
      end
      // 0x10 lies outside the map
      apb_write(8'h10, 32'h5A5A_5A5A, err);
      check_data("pslverr", data_t'(err), 32'd1);
      apb_read(8'h10, rd, err);
      check_data("pslverr", data_t'(err), 32'd1);
   endtask

   task automatic sync_timing();
      int n;
      int low_w;
      int high_w;
      set_ctrl(1'b1, vga_video_pkg::PAT_SOLID);
      wait_sync(1'b0, 1'b1, n);
      wait_sync(1'b0, 1'b0, n);
      wait_sync(1'b0, 1'b1, low_w);
      wait_sync(1'b0, 1'b0, high_w);
      check_data("hsync low width", low_w, H_PULSE);
      check_data("hsync period", low_w + high_w, H_TOTAL);
      wait_sync(1'b1, 1'b1, n);
      wait_sync(1'b1, 1'b0, n);
      wait_sync(1'b1, 1'b1, low_w);
      wait_sync(1'b1, 1'b0, high_w);
      check_data("vsync low width", low_w, V_PULSE * H_TOTAL);
      check_data("vsync period", low_w + high_w, V_TOTAL * H_TOTAL);
   endtask

   task automatic solid_mode();
      data_t val;
      logic  err;
      val       = $random(seed);
      cur_color = val[2:0];
      apb_write(vga_regmap_pkg::REG_COLOR, val, err);
      set_ctrl(1'b1, vga_video_pkg::PAT_SOLID);
      scan_frame();
   endtask

   task automatic bar_and_checker();
      logic err;
      set_ctrl(1'b1, vga_video_pkg::PAT_BARS);
      // shift 1 walks all eight colours across 16 pixels
      cur_shift = 4'd1;
      apb_write(vga_regmap_pkg::REG_BARW, 32'd1, err);
      scan_frame();
      cur_shift = 4'd2;
      apb_write(vga_regmap_pkg::REG_BARW, 32'd2, err);
      scan_frame();
      set_ctrl(1'b1, vga_video_pkg::PAT_CHECKER);
      scan_frame();
   endtask

   task automatic frame_count_and_disable();
      int    k;
      int    n;
      data_t rd;
      data_t frozen;
      logic  err;
      apb_write(vga_regmap_pkg::REG_FRAMES, '0, err);
      for (k = 0; k < N_FRAMES; k++)
      begin
         wait_sync(1'b1, 1'b1, n);
         wait_sync(1'b1, 1'b0, n);
      end
      apb_read(vga_regmap_pkg::REG_FRAMES, rd, err);
      // clear may land before or after this frame's start
      if (rd != N_FRAMES && rd != N_FRAMES - 1)
         check_data("frame count", rd, N_FRAMES);
      set_ctrl(1'b0, vga_video_pkg::PAT_SOLID);
      apb_read(vga_regmap_pkg::REG_FRAMES, frozen, err);
      repeat (2 * H_TOTAL * V_TOTAL)
      begin
         @(negedge clk_85MHz);
         check_data("hsync", data_t'(hsync), 32'd1);
         check_rgb("rgb", rgb, 3'b000);
      end
      apb_read(vga_regmap_pkg::REG_FRAMES, rd, err);
      check_data("frame count held", rd, frozen);
   endtask

   initial
   begin
      rst_n     = 1'b0;
      psel      = 1'b0;
      penable   = 1'b0;
      pwrite    = 1'b0;
      paddr     = '0;
      pwdata    = '0;
      cur_mode  = vga_video_pkg::PAT_SOLID;
      cur_color = '0;
      cur_shift = '0;
      repeat (8) @(posedge clk_85MHz);
      #1;
      rst_n = 1'b1;
      reset_state();
      register_access();
      sync_timing();
      solid_mode();
      bar_and_checker();
      frame_count_and_disable();
      print_counts();
      if (value_errors == 0 && other_errors == 0)
         $display("Regression passed");
      else
         $display("Regression failed");
      $finish;
   end

endmodule

/* vga_subsys.f */
+incdir+tests
src/vga_video_pkg.sv
src/vga_regmap_pkg.sv
src/apb_vga_regs.sv
src/raster_timing_gen.sv
src/pattern_gen.sv
src/vga_output_stage.sv
src/vga_subsys_top.sv
tests/tb_vga_subsys.sv
